// ==== sim.f ====
src/cfr_pkg.sv
src/cfr_regs.sv
src/cfr_peak_detect.sv
src/cfr_delay_line.sv
src/cfr_pulse_cancel.sv
src/cfr_top.sv
verification/cfr_tb.sv

// ==== Bender.yml ====
package:
  name: cfr

sources:
  - src/cfr_pkg.sv
  - src/cfr_regs.sv
  - src/cfr_peak_detect.sv
  - src/cfr_delay_line.sv
  - src/cfr_pulse_cancel.sv
  - src/cfr_top.sv
  - target: test
    files:
      - verification/cfr_tb.sv

// ==== verification/cfr_tb.sv ====
/*
 * CFR stage testbench
 * Random register and stream stimulus against a reference model
 */
`timescale 1ns/100ps
`default_nettype none

module cfr_tb;

    import cfr_pkg::*;

    localparam logic [31:0] dut_id = 32'h0cf0_0001;

    logic        clk = 1'b0;
    logic        rst;
    logic [9:0]  wr_addr;
    logic        wr_req;
    logic [31:0] wr_data;
    logic        wr_ack;
    logic [9:0]  rd_addr;
    logic        rd_req;
    logic [31:0] rd_data;
    logic        rd_ack;
    logic        in_valid;
    logic [15:0] in_i;
    logic [15:0] in_q;
    logic        out_valid;
    logic signed [15:0] out_i;
    logic signed [15:0] out_q;

    logic [31:0] lfsr = 32'hd195;
    int cyc = 0;
    int mismatches = 0;
    int failures = 0;

    // Reference model state
    int sh_pc_en = 0;
    int sh_det = 17'h1ffff;
    int sh_clip = 17'h1ffff;
    int sh_hc_en = 0;
    int sh_hc_th = 17'h1ffff;
    int hold_i = 0;
    int hold_q = 0;
    int pulse_i [pulse_len];
    int pulse_q [pulse_len];
    bit running = 1'b0;
    int idx = 0;
    int line_i[$];
    int line_q[$];

    // Expected outputs with the oldest first
    int exp_i[$];
    int exp_q[$];
    int exp_lim[$];
    int exp_due[$];

    cfr_top #(
        .ID(dut_id)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .wr_addr(wr_addr),
        .wr_req(wr_req),
        .wr_data(wr_data),
        .wr_ack(wr_ack),
        .rd_addr(rd_addr),
        .rd_req(rd_req),
        .rd_data(rd_data),
        .rd_ack(rd_ack),
        .in_valid(in_valid),
        .in_i(in_i),
        .in_q(in_q),
        .out_valid(out_valid),
        .out_i(out_i),
        .out_q(out_q)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'ha3000000 : 32'h0);
        end
        return r;
    endfunction

    function automatic int rand_sample();
        logic [15:0] b;
        b = rand_bits(16);
        return int'($signed(b));
    endfunction

    // Saturating subtract, then clamp to +-lim when lim is not negative
    function automatic int subtract_clip(input int x, input int c, input int lim);
        int y;
        y = x - c;
        if (y > 32767) y = 32767;
        else if (y < -32768) y = -32768;
        if (lim >= 0) begin
            if (y > lim) y = lim;
            else if (y < -lim) y = -lim;
        end
        return y;
    endfunction

    function automatic logic [31:0] expected_read(input int addr);
        case (addr)
            reg_id:               return dut_id;
            reg_pc_enable:        return 32'(sh_pc_en);
            reg_pc_detect_thresh: return 32'(sh_det);
            reg_pc_clip_thresh:   return 32'(sh_clip);
            reg_hc_enable:        return 32'(sh_hc_en);
            reg_hc_thresh:        return 32'(sh_hc_th);
            default:              return rd_filler;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, want);
        end
    endtask

    task automatic write_reg(input int addr, input logic [31:0] data);
        int n;
        @(negedge clk);
        in_valid = 1'b0;
        wr_addr = addr[9:0];
        wr_data = data;
        wr_req = 1'b1;
        // The table strobe writes both held halves into the shadow table
        case (addr)
            reg_pc_enable:        sh_pc_en = data[0];
            reg_pc_detect_thresh: sh_det = data[16:0];
            reg_pc_clip_thresh:   sh_clip = data[16:0];
            reg_hc_enable:        sh_hc_en = data[0];
            reg_hc_thresh:        sh_hc_th = data[16:0];
            default: begin
                if (addr >= reg_cpw_i_base && addr < reg_cpw_q_base + pulse_len) begin
                    if (addr < reg_cpw_q_base) hold_i = int'($signed(data[15:0]));
                    else hold_q = int'($signed(data[15:0]));
                    pulse_i[addr % pulse_len] = hold_i;
                    pulse_q[addr % pulse_len] = hold_q;
                end
            end
        endcase
        n = 0;
        do begin
            @(negedge clk);
            wr_req = 1'b0;
            n++;
        end while (!wr_ack && n < 10);
        if (!wr_ack) begin
            failures++;
            $display("ERROR t=%0t write to address %0d was never acknowledged", $time, addr);
        end else begin
            check_value("wr_ack latency", n, 1);
        end
    endtask

    task automatic read_reg(input int addr);
        int n;
        logic [31:0] want;
        want = expected_read(addr);
        @(negedge clk);
        in_valid = 1'b0;
        rd_addr = addr[9:0];
        rd_req = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            rd_req = 1'b0;
            n++;
        end while (!rd_ack && n < 10);
        if (!rd_ack) begin
            failures++;
            $display("ERROR t=%0t read of address %0d was never acknowledged", $time, addr);
        end else begin
            check_value("rd_ack latency", n, 1);
            check_value("rd_data", rd_data, want);
        end
    endtask

    // ************************************************************************
    // Stream driver with the reference model
    // ************************************************************************
    task automatic drive_step(input int si, input int sq);
        int di;
        int dq;
        int ci;
        int cq;
        int ai;
        int aq;
        int mag;
        int lim;
        bit busy;
        @(negedge clk);
        in_valid = 1'b1;
        in_i = si[15:0];
        in_q = sq[15:0];
        di = line_i.pop_front();
        dq = line_q.pop_front();
        line_i.push_back(si);
        line_q.push_back(sq);
        // A step covered by a running pulse cannot start another one
        busy = running;
        ci = 0;
        cq = 0;
        if (running) begin
            ci = pulse_i[idx];
            cq = pulse_q[idx];
            if (idx == pulse_len - 1) running = 1'b0;
            else idx++;
        end
        ai = (si < 0) ? -si : si;
        aq = (sq < 0) ? -sq : sq;
        mag = (ai > aq) ? ai + aq / 2 : aq + ai / 2;
        // A new pulse starts on the next step
        if (sh_pc_en != 0 && !busy && mag > sh_det) begin
            running = 1'b1;
            idx = 0;
        end
        lim = -1;
        if (sh_hc_en != 0) lim = (sh_hc_th > 32767) ? 32767 : sh_hc_th;
        exp_i.push_back(subtract_clip(di, ci, lim));
        exp_q.push_back(subtract_clip(dq, cq, lim));
        exp_lim.push_back(lim);
        exp_due.push_back(cyc + 2);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_i.size() > 0 && n < 16) begin
            @(negedge clk);
            in_valid = 1'b0;
            n++;
        end
        if (exp_i.size() > 0) begin
            failures++;
            $display("ERROR t=%0t out_valid missing for %0d samples", $time, exp_i.size());
            exp_i.delete();
            exp_q.delete();
            exp_lim.delete();
            exp_due.delete();
        end
    endtask

    // Output monitor
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_i.size() == 0) begin
                failures++;
                $display("ERROR t=%0t out_valid high with no sample expected", $time);
            end else begin
                check_value("out_valid latency", cyc, exp_due.pop_front());
                check_value("out_i", out_i, exp_i.pop_front());
                check_value("out_q", out_q, exp_q.pop_front());
                if (exp_lim[0] >= 0) begin
                    check_value("out_i clamp", out_i <= exp_lim[0] && out_i >= -exp_lim[0], 1);
                    check_value("out_q clamp", out_q <= exp_lim[0] && out_q >= -exp_lim[0], 1);
                end
                void'(exp_lim.pop_front());
            end
        end
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************
    initial begin
        rst = 1'b1;
        wr_addr = '0;
        wr_req = 1'b0;
        wr_data = '0;
        rd_addr = '0;
        rd_req = 1'b0;
        in_valid = 1'b0;
        in_i = '0;
        in_q = '0;
        repeat (delay_len) begin
            line_i.push_back(0);
            line_q.push_back(0);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Register access
        repeat (20) write_reg(reg_pc_enable + rand_bits(3) % 5, rand_bits(32));
        for (int a = reg_id; a <= reg_hc_thresh; a++) read_reg(a);
        repeat (24) read_reg(rand_bits(10));

        // Pass-through with both enables off
        write_reg(reg_pc_enable, 0);
        write_reg(reg_hc_enable, 0);
        repeat (300) begin
            drive_step(rand_sample(), rand_sample());
            idle_cycles(rand_bits(2));
        end
        wait_drain();

        // Peak cancellation after loading I then Q for each table entry
        for (int a = 0; a < pulse_len; a++) begin
            write_reg(reg_cpw_i_base + a, rand_bits(32));
            write_reg(reg_cpw_q_base + a, rand_bits(32));
        end
        write_reg(reg_pc_detect_thresh, 24576 + rand_bits(13));
        write_reg(reg_pc_enable, 1);
        repeat (700) begin
            drive_step(rand_sample(), rand_sample());
            idle_cycles(rand_bits(1));
        end
        wait_drain();

        // Hard clip with thresholds that may exceed full scale
        write_reg(reg_hc_enable, 1);
        repeat (6) begin
            write_reg(reg_hc_thresh, rand_bits(17));
            repeat (80) begin
                drive_step(rand_sample(), rand_sample());
                idle_cycles(rand_bits(1));
            end
        end
        wait_drain();

        // Live reconfiguration while streaming
        repeat (400) begin
            case (rand_bits(3))
                0: write_reg(reg_pc_detect_thresh, 24576 + rand_bits(13));
                1: write_reg(reg_hc_thresh, rand_bits(17));
                2: write_reg(reg_cpw_i_base + rand_bits(8), rand_bits(32));
                3: write_reg(reg_cpw_q_base + rand_bits(8), rand_bits(32));
                default: drive_step(rand_sample(), rand_sample());
            endcase
        end
        wait_drain();

        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/cfr_top.sv ====
/*
 * CFR stage top level
 * Register block, peak detector, delay line and pulse cancellation
 */
`timescale 1ns/100ps
`default_nettype none

module cfr_top #(
    parameter logic [cfr_pkg::data_width-1:0] ID = '0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    // Register bus
    input  logic [cfr_pkg::addr_width-1:0]          wr_addr,
    input  logic                                    wr_req,
    input  logic [cfr_pkg::data_width-1:0]          wr_data,
    output logic                                    wr_ack,
    input  logic [cfr_pkg::addr_width-1:0]          rd_addr,
    input  logic                                    rd_req,
    output logic [cfr_pkg::data_width-1:0]          rd_data,
    output logic                                    rd_ack,
    // Sample stream
    input  logic                                    in_valid,
    input  logic signed [cfr_pkg::sample_width-1:0] in_i,
    input  logic signed [cfr_pkg::sample_width-1:0] in_q,
    output logic                                    out_valid,
    output logic signed [cfr_pkg::sample_width-1:0] out_i,
    output logic signed [cfr_pkg::sample_width-1:0] out_q
);

    import cfr_pkg::*;

    logic                           pc_enable;
    logic [thresh_width-1:0]        detect_thresh;
    logic                           hc_enable;
    logic [thresh_width-1:0]        hc_thresh;
    logic                           cpw_wr_en;
    logic [pulse_addr_width-1:0]    cpw_wr_addr;
    logic [sample_width-1:0]        cpw_wr_data_i;
    logic [sample_width-1:0]        cpw_wr_data_q;
    logic                           pulse_busy;
    logic                           peak;
    logic                           step_d;
    logic signed [sample_width-1:0] dly_i;
    logic signed [sample_width-1:0] dly_q;

    cfr_regs #(
        .ID(ID)
    ) regs0 (
        .clk(clk),
        .rst(rst),
        .wr_addr(wr_addr),
        .wr_req(wr_req),
        .wr_data(wr_data),
        .wr_ack(wr_ack),
        .rd_addr(rd_addr),
        .rd_req(rd_req),
        .rd_data(rd_data),
        .rd_ack(rd_ack),
        .pc_enable(pc_enable),
        .detect_thresh(detect_thresh),
        // Held for read back only
        .clip_thresh(),
        .hc_enable(hc_enable),
        .hc_thresh(hc_thresh),
        .cpw_wr_en(cpw_wr_en),
        .cpw_wr_addr(cpw_wr_addr),
        .cpw_wr_data_i(cpw_wr_data_i),
        .cpw_wr_data_q(cpw_wr_data_q)
    );

    cfr_peak_detect peak0 (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_i(in_i),
        .in_q(in_q),
        .pc_enable(pc_enable),
        .detect_thresh(detect_thresh),
        .pulse_busy(pulse_busy),
        .peak(peak)
    );

    cfr_delay_line delay0 (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_i(in_i),
        .in_q(in_q),
        .step_d(step_d),
        .dly_i(dly_i),
        .dly_q(dly_q)
    );

    cfr_pulse_cancel cancel0 (
        .clk(clk),
        .rst(rst),
        .step_d(step_d),
        .peak(peak),
        .dly_i(dly_i),
        .dly_q(dly_q),
        .hc_enable(hc_enable),
        .hc_thresh(hc_thresh),
        .cpw_wr_en(cpw_wr_en),
        .cpw_wr_addr(cpw_wr_addr),
        .cpw_wr_data_i(cpw_wr_data_i),
        .cpw_wr_data_q(cpw_wr_data_q),
        .pulse_busy(pulse_busy),
        .out_valid(out_valid),
        .out_i(out_i),
        .out_q(out_q)
    );

endmodule

`default_nettype wire

// ==== src/cfr_pulse_cancel.sv ====
/*
 * CFR pulse cancellation
 * Pulse table, coefficient sequencer, saturating subtraction and hard clip
 */
`timescale 1ns/100ps
`default_nettype none

module cfr_pulse_cancel (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    step_d,
    input  logic                                    peak,
    input  logic signed [cfr_pkg::sample_width-1:0] dly_i,
    input  logic signed [cfr_pkg::sample_width-1:0] dly_q,
    input  logic                                    hc_enable,
    input  logic [cfr_pkg::thresh_width-1:0]        hc_thresh,
    input  logic                                    cpw_wr_en,
    input  logic [cfr_pkg::pulse_addr_width-1:0]    cpw_wr_addr,
    input  logic [cfr_pkg::sample_width-1:0]        cpw_wr_data_i,
    input  logic [cfr_pkg::sample_width-1:0]        cpw_wr_data_q,
    output logic                                    pulse_busy,
    output logic                                    out_valid,
    output logic signed [cfr_pkg::sample_width-1:0] out_i,
    output logic signed [cfr_pkg::sample_width-1:0] out_q
);

    import cfr_pkg::*;

    logic signed [sample_width-1:0] tab_i [pulse_len];
    logic signed [sample_width-1:0] tab_q [pulse_len];
    logic                           running;
    logic [pulse_addr_width-1:0]    idx;
    logic                           last;
    logic signed [sample_width-1:0] coef_i;
    logic signed [sample_width-1:0] coef_q;
    logic signed [sample_width-1:0] hc_limit;

    // Saturating subtract, then optional clamp to +-lim
    function automatic logic signed [sample_width-1:0] cancel_clip(
        input logic signed [sample_width-1:0] x,
        input logic signed [sample_width-1:0] c,
        input logic                           clip_en,
        input logic signed [sample_width-1:0] lim
    );
        logic signed [sample_width:0]   diff;
        logic signed [sample_width-1:0] y;
        diff = {x[sample_width-1], x} - {c[sample_width-1], c};
        if (diff[sample_width] != diff[sample_width-1]) begin
            y = diff[sample_width] ? {1'b1, {(sample_width-1){1'b0}}}
                                   : {1'b0, {(sample_width-1){1'b1}}};
        end else begin
            y = diff[sample_width-1:0];
        end
        if (clip_en && (y > lim)) begin
            y = lim;
        end else if (clip_en && (y < -lim)) begin
            y = -lim;
        end
        return y;
    endfunction

    always_ff @(posedge clk) begin
        if (cpw_wr_en) begin
            tab_i[cpw_wr_addr] <= cpw_wr_data_i;
            tab_q[cpw_wr_addr] <= cpw_wr_data_q;
        end
    end

    // ************************************************************************
    // Pulse sequencer
    // ************************************************************************
    // running means the next step to arrive is covered by the pulse
    assign last = (idx == pulse_addr_width'(pulse_len - 1));

    // Looks one step ahead when a step is being consumed this cycle
    assign pulse_busy = peak || (running && !(step_d && last));

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            idx     <= '0;
        end else if (step_d) begin
            if (peak) begin
                running <= 1'b1;
                idx     <= '0;
            end else if (running) begin
                idx <= idx + 1'b1;
                if (last) begin
                    running <= 1'b0;
                end
            end
        end
    end

    assign coef_i = running ? tab_i[idx] : '0;
    assign coef_q = running ? tab_q[idx] : '0;

    // Threshold above full scale saturates at 32767
    assign hc_limit = (hc_thresh > thresh_width'(2**(sample_width-1) - 1))
                      ? {1'b0, {(sample_width-1){1'b1}}}
                      : hc_thresh[sample_width-1:0];

    // ************************************************************************
    // Output stage
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= step_d;
        end
    end

    always_ff @(posedge clk) begin
        if (step_d) begin
            out_i <= cancel_clip(dly_i, coef_i, hc_enable, hc_limit);
            out_q <= cancel_clip(dly_q, coef_q, hc_enable, hc_limit);
        end
    end

endmodule

`default_nettype wire

// ==== src/cfr_delay_line.sv ====
/*
 * CFR delay line
 * Step-driven I/Q shift register, aligns samples with the pulse center
 */
`timescale 1ns/100ps
`default_nettype none

module cfr_delay_line (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    in_valid,
    input  logic signed [cfr_pkg::sample_width-1:0] in_i,
    input  logic signed [cfr_pkg::sample_width-1:0] in_q,
    output logic                                    step_d,
    output logic signed [cfr_pkg::sample_width-1:0] dly_i,
    output logic signed [cfr_pkg::sample_width-1:0] dly_q
);

    import cfr_pkg::*;

    // Entry 0 holds the newest sample
    logic signed [sample_width-1:0] sr_i [delay_len];
    logic signed [sample_width-1:0] sr_q [delay_len];

    always_ff @(posedge clk) begin
        if (rst) begin
            step_d <= 1'b0;
            for (int k = 0; k < delay_len; k++) begin
                sr_i[k] <= '0;
                sr_q[k] <= '0;
            end
        end else begin
            step_d <= in_valid;
            if (in_valid) begin
                for (int k = delay_len - 1; k > 0; k--) begin
                    sr_i[k] <= sr_i[k-1];
                    sr_q[k] <= sr_q[k-1];
                end
                sr_i[0] <= in_i;
                sr_q[0] <= in_q;
            end
        end
    end

    // Oldest entry leaves as the new one enters
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dly_i <= sr_i[delay_len-1];
            dly_q <= sr_q[delay_len-1];
        end
    end

endmodule

`default_nettype wire

// ==== src/cfr_peak_detect.sv ====
/*
 * CFR peak detector
 * Estimates sample magnitude as max + min/2 and flags samples above threshold
 */
`timescale 1ns/100ps
`default_nettype none

module cfr_peak_detect (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    in_valid,
    input  logic signed [cfr_pkg::sample_width-1:0] in_i,
    input  logic signed [cfr_pkg::sample_width-1:0] in_q,
    input  logic                                    pc_enable,
    input  logic [cfr_pkg::thresh_width-1:0]        detect_thresh,
    input  logic                                    pulse_busy,
    output logic                                    peak
);

    import cfr_pkg::*;

    logic [thresh_width-1:0] abs_i;
    logic [thresh_width-1:0] abs_q;
    logic [thresh_width-1:0] mag;

    // One extra bit so that -32768 maps to 32768
    assign abs_i = in_i[sample_width-1] ? -thresh_width'(in_i) : thresh_width'(in_i);
    assign abs_q = in_q[sample_width-1] ? -thresh_width'(in_q) : thresh_width'(in_q);

    assign mag = (abs_i > abs_q) ? abs_i + (abs_q >> 1)
                                 : abs_q + (abs_i >> 1);

    // Overlapping peaks are dropped here, while a pulse is in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            peak <= 1'b0;
        end else begin
            peak <= in_valid && pc_enable && !pulse_busy && (mag > detect_thresh);
        end
    end

endmodule

`default_nettype wire

// ==== src/cfr_regs.sv ====
/*
 * CFR register block
 * Request/acknowledge register bus holding the stage controls and
 * forwarding writes of the pulse windows as table write strobes
 */
`timescale 1ns/100ps
`default_nettype none

module cfr_regs #(
    parameter logic [cfr_pkg::data_width-1:0] ID = '0
) (
    input  logic                                clk,
    input  logic                                rst,
    // Write channel
    input  logic [cfr_pkg::addr_width-1:0]      wr_addr,
    input  logic                                wr_req,
    input  logic [cfr_pkg::data_width-1:0]      wr_data,
    output logic                                wr_ack,
    // Read channel
    input  logic [cfr_pkg::addr_width-1:0]      rd_addr,
    input  logic                                rd_req,
    output logic [cfr_pkg::data_width-1:0]      rd_data,
    output logic                                rd_ack,
    // Controls
    output logic                                pc_enable,
    output logic [cfr_pkg::thresh_width-1:0]    detect_thresh,
    output logic [cfr_pkg::thresh_width-1:0]    clip_thresh,
    output logic                                hc_enable,
    output logic [cfr_pkg::thresh_width-1:0]    hc_thresh,
    // Pulse table writes
    output logic                                cpw_wr_en,
    output logic [cfr_pkg::pulse_addr_width-1:0] cpw_wr_addr,
    output logic [cfr_pkg::sample_width-1:0]    cpw_wr_data_i,
    output logic [cfr_pkg::sample_width-1:0]    cpw_wr_data_q
);

    import cfr_pkg::*;

    logic wr_cpw_i;
    logic wr_cpw_q;

    // Pulse windows, decoded by range
    assign wr_cpw_i = wr_req && (wr_addr >= reg_cpw_i_base)
                      && (wr_addr < reg_cpw_i_base + pulse_len);
    assign wr_cpw_q = wr_req && (wr_addr >= reg_cpw_q_base)
                      && (wr_addr < reg_cpw_q_base + pulse_len);

    // ************************************************************************
    // Control registers
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_enable     <= 1'b0;
            detect_thresh <= '1;
            clip_thresh   <= '1;
            hc_enable     <= 1'b0;
            hc_thresh     <= '1;
        end else if (wr_req) begin
            case (wr_addr)
                reg_pc_enable:        pc_enable     <= wr_data[0];
                reg_pc_detect_thresh: detect_thresh <= wr_data[thresh_width-1:0];
                reg_pc_clip_thresh:   clip_thresh   <= wr_data[thresh_width-1:0];
                reg_hc_enable:        hc_enable     <= wr_data[0];
                reg_hc_thresh:        hc_thresh     <= wr_data[thresh_width-1:0];
                default: ;
            endcase
        end
    end

    // ************************************************************************
    // Pulse table write forwarding
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            cpw_wr_en <= 1'b0;
        end else begin
            cpw_wr_en <= wr_cpw_i || wr_cpw_q;
        end
    end

    // The other half of the pair keeps its last value
    always_ff @(posedge clk) begin
        if (wr_cpw_i || wr_cpw_q) begin
            cpw_wr_addr <= wr_addr[pulse_addr_width-1:0];
        end
        if (wr_cpw_i) begin
            cpw_wr_data_i <= wr_data[sample_width-1:0];
        end
        if (wr_cpw_q) begin
            cpw_wr_data_q <= wr_data[sample_width-1:0];
        end
    end

    // ************************************************************************
    // Read back and acknowledges
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_req) begin
            case (rd_addr)
                reg_id:               rd_data <= ID;
                reg_pc_enable:        rd_data <= data_width'(pc_enable);
                reg_pc_detect_thresh: rd_data <= data_width'(detect_thresh);
                reg_pc_clip_thresh:   rd_data <= data_width'(clip_thresh);
                reg_hc_enable:        rd_data <= data_width'(hc_enable);
                reg_hc_thresh:        rd_data <= data_width'(hc_thresh);
                // Pulse windows read as unmapped
                default:              rd_data <= rd_filler;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_req;
            rd_ack <= rd_req;
        end
    end

endmodule

`default_nettype wire

// ==== src/cfr_pkg.sv ====
/*
 * CFR shared definitions
 * Sample and threshold widths, register map, pulse and delay lengths
 */
`default_nettype none

package cfr_pkg;

    // ************************************************************************
    // Widths and lengths
    // ************************************************************************
    localparam int addr_width       = 10;
    localparam int data_width       = 32;
    localparam int sample_width     = 16;
    // Thresholds and magnitude estimate share one width
    localparam int thresh_width     = 17;
    localparam int pulse_len        = 256;
    localparam int pulse_addr_width = 8;
    // Half of the pulse length, so a pulse is centered on its peak
    localparam int delay_len        = 128;

    // ************************************************************************
    // Register map
    // ************************************************************************
    localparam int reg_id               = 0;
    localparam int reg_pc_enable        = 8;
    localparam int reg_pc_detect_thresh = 9;
    localparam int reg_pc_clip_thresh   = 10;
    localparam int reg_hc_enable        = 11;
    localparam int reg_hc_thresh        = 12;

    // Pulse coefficient windows, pulse_len words each, write only
    localparam int reg_cpw_i_base       = 512;
    localparam int reg_cpw_q_base       = 768;

    // Returned for unmapped reads
    localparam logic [data_width-1:0] rd_filler = 32'hdeadbeef;

endpackage

`default_nettype wire
